//--- sources.f
+incdir+include
logic/cpu_pkg.sv
logic/branch_if.sv
logic/fetch_queue.sv
logic/branch_resolver.sv
logic/pipe_ctrl.sv
logic/redirect_unit.sv
logic/ctrl_top.sv
tb/tb_ctrl_top.sv

//--- Bender.yml
package:
  name: dual_issue_ctrl

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/cpu_pkg.sv
      - logic/branch_if.sv
      - logic/fetch_queue.sv
      - logic/branch_resolver.sv
      - logic/pipe_ctrl.sv
      - logic/redirect_unit.sv
      - logic/ctrl_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_ctrl_top.sv

//--- tb/tb_ctrl_top.sv
`default_nettype none
`timescale 1ns/1ns

`include "cpu_settings.svh"

module tb_ctrl_top;
	import cpu_pkg::*;

	localparam int TIMEOUT = 20;

	typedef struct packed {
		logic  valid;
		addr_t pc;
		logic  is_branch;
		logic  pred;
		logic  act;
		addr_t tgt;
	} lane_t;

	// Vectors are {IF, ID, EX, MM} stall then flush
	typedef struct packed {
		logic [2:0]  stall_req;   // ID, EX, MM
		lane_t       lane0;
		lane_t       lane1;
		except_req_t exc;
		logic        push;
		logic [7:0]  vec_b;
		logic [7:0]  vec_c;
		logic [1:0]  dslot;       // Delay slot outside the lanes, b then c
		logic        redirect;
		addr_t       redirect_pc;
		int          hold_cycles;
	} row_t;

	localparam lane_t       LANE_OFF = '0;
	localparam except_req_t EXC_NONE = '0;

	logic                           clk;
	logic                           rst;
	logic                           fetch_valid_i;
	addr_t                          fetch_pc_i;
	logic                           fetch_ready_o;
	logic                           issue_valid_o;
	addr_t                          issue_pc_o;
	pipeline_exec_t [`LANE_NUM-1:0] exec_i;
	logic [`LANE_NUM-1:0]           is_branch_i;
	logic [`LANE_NUM-1:0]           predicted_taken_i;
	logic [`LANE_NUM-1:0]           actual_taken_i;
	addr_t [`LANE_NUM-1:0]          actual_target_i;
	except_req_t                    except_req_i;
	logic                           stall_from_id_i;
	logic                           stall_from_ex_i;
	logic                           stall_from_mm_i;
	logic                           stall_if_o;
	logic                           stall_id_o;
	logic                           stall_ex_o;
	logic                           stall_mm_o;
	logic                           flush_if_o;
	logic                           flush_id_o;
	logic                           flush_ex_o;
	logic                           flush_mm_o;
	logic                           delayslot_not_exec_o;
	logic                           redirect_valid_o;
	addr_t                          redirect_pc_o;
	logic                           redirect_ready_i;

	int    seed = 86328;
	string phase;
	row_t  rows [$];

	ctrl_top dut (.*);

	always #10 clk = ~clk;

	// **************************************************
	// Helpers
	// **************************************************

	task automatic report_fail();
		$display("*** FAILED ***");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_vec(input string name, input logic [3:0] got, input logic [3:0] exp);
		if (got !== exp) begin
			$display("Error: %s = %h, expected %h (%s)", name, got, exp, phase);
			report_fail();
		end
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			$display("Error: %s = %h, expected %h (%s)", name, got, exp, phase);
			report_fail();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error: %s = %h, expected %h (%s)", name, got, exp, phase);
			report_fail();
		end
	endtask

	function automatic logic [3:0] stall_now();
		return {stall_if_o, stall_id_o, stall_ex_o, stall_mm_o};
	endfunction

	function automatic logic [3:0] flush_now();
		return {flush_if_o, flush_id_o, flush_ex_o, flush_mm_o};
	endfunction

	function automatic addr_t random_pc();
		return addr_t'($random(seed)) & ~addr_t'(3);  // Word aligned
	endfunction

	function automatic lane_t branch_lane(addr_t pc, logic pred, logic act, addr_t tgt);
		return '{1'b1, pc, 1'b1, pred, act, tgt};
	endfunction

	function automatic lane_t plain_lane(addr_t pc);
		return '{1'b1, pc, 1'b0, 1'b0, 1'b0, '0};
	endfunction

	function automatic except_req_t exc_req(logic alpha, addr_t tgt);
		return '{1'b1, alpha, tgt};
	endfunction

	// Back to the drive point, 2 ns after the edge
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic set_lanes(input lane_t l0, input lane_t l1, input logic branch_en);
		lane_t lanes [2];
		lanes[0] = l0;
		lanes[1] = l1;
		for (int i = 0; i < 2; i++) begin
			exec_i[i].valid      = lanes[i].valid;
			exec_i[i].pc         = lanes[i].pc;
			is_branch_i[i]       = lanes[i].is_branch & branch_en;
			predicted_taken_i[i] = lanes[i].pred;
			actual_taken_i[i]    = lanes[i].act;
			actual_target_i[i]   = lanes[i].tgt;
		end
	endtask

	// Returns at the sample point of the matching cycle
	task automatic wait_redirect(input logic level);
		int cycles;
		cycles = 0;
		#10;
		while (redirect_valid_o !== level) begin
			if (cycles == TIMEOUT) begin
				$display("Timed out waiting for redirect_valid_o to become %0d (%s)", level, phase);
				report_fail();
			end
			cycles++;
			next_cycle();
			#10;
		end
	endtask

	task automatic wait_fetch_ready();
		int cycles;
		cycles = 0;
		#10;
		while (fetch_ready_o !== 1'b1) begin
			if (cycles == TIMEOUT) begin
				$display("Timed out waiting for fetch_ready_o (%s)", phase);
				report_fail();
			end
			cycles++;
			next_cycle();
			#10;
		end
	endtask

	// **************************************************
	// Stimulus table
	// **************************************************

	task automatic build_table();
		// Stall priority
		rows.push_back(row_t'{3'b001, LANE_OFF, LANE_OFF, EXC_NONE, 1'b0,
			8'b1111_0000, 8'h00, 2'b00, 1'b0, '0, 0});
		rows.push_back(row_t'{3'b010, LANE_OFF, LANE_OFF, EXC_NONE, 1'b0,
			8'b1110_0000, 8'h00, 2'b00, 1'b0, '0, 0});
		rows.push_back(row_t'{3'b100, LANE_OFF, LANE_OFF, EXC_NONE, 1'b0,
			8'b1100_0000, 8'h00, 2'b00, 1'b0, '0, 0});
		rows.push_back(row_t'{3'b000, LANE_OFF, LANE_OFF, EXC_NONE, 1'b0,
			8'b0000_0000, 8'h00, 2'b00, 1'b0, '0, 0});
		rows.push_back(row_t'{3'b111, LANE_OFF, LANE_OFF, EXC_NONE, 1'b0,
			8'b1111_0000, 8'h00, 2'b00, 1'b0, '0, 0});
		rows.push_back(row_t'{3'b110, LANE_OFF, LANE_OFF, EXC_NONE, 1'b0,
			8'b1110_0000, 8'h00, 2'b00, 1'b0, '0, 0});
		// Exceptions, the last one beside a mispredict
		rows.push_back(row_t'{3'b000, LANE_OFF, LANE_OFF, exc_req(1'b0, 32'h0000_0180), 1'b0,
			8'b0000_1100, 8'h00, 2'b00, 1'b1, 32'h0000_0180, 0});
		rows.push_back(row_t'{3'b000, LANE_OFF, LANE_OFF, exc_req(1'b1, 32'hbfc0_0380), 1'b0,
			8'b0000_1111, 8'h00, 2'b00, 1'b1, 32'hbfc0_0380, 2});
		rows.push_back(row_t'{3'b000, branch_lane(32'h0000_0400, 1'b0, 1'b1, 32'h0000_0800),
			plain_lane(32'h0000_0404), exc_req(1'b0, 32'h0000_0180), 1'b0,
			8'b0000_1100, 8'h00, 2'b00, 1'b1, 32'h0000_0180, 0});
		// Mispredicts with the slot in lane 1, taken then not taken
		rows.push_back(row_t'{3'b000, branch_lane(32'h0000_1000, 1'b0, 1'b1, 32'h0000_2000),
			plain_lane(32'h0000_1004), EXC_NONE, 1'b0,
			8'b0000_1100, 8'h00, 2'b00, 1'b1, 32'h0000_2000, 0});
		rows.push_back(row_t'{3'b000, branch_lane(32'h0000_3000, 1'b1, 1'b0, 32'h0000_5000),
			plain_lane(32'h0000_3004), EXC_NONE, 1'b0,
			8'b0000_1100, 8'h00, 2'b00, 1'b1, 32'h0000_3008, 3});
		// Correct prediction
		rows.push_back(row_t'{3'b000, branch_lane(32'h0000_8000, 1'b1, 1'b1, 32'h0000_9000),
			plain_lane(32'h0000_8004), EXC_NONE, 1'b0,
			8'b0000_0000, 8'h00, 2'b00, 1'b0, '0, 0});
		// Lane 1 branch waits for its slot in the queue
		rows.push_back(row_t'{3'b000, plain_lane(32'h0000_6000),
			branch_lane(32'h0000_6004, 1'b0, 1'b1, 32'h0000_7000), EXC_NONE, 1'b1,
			8'b1110_0000, 8'b0000_1100, 2'b11, 1'b1, 32'h0000_7000, 0});
	endtask

	task automatic run_row(input row_t r);
		// Lanes present their branches
		set_lanes(r.lane0, r.lane1, 1'b1);
		{stall_from_id_i, stall_from_ex_i, stall_from_mm_i} = 3'b000;
		except_req_i = EXC_NONE;
		next_cycle();

		// Resolved records visible, slots still in EX
		set_lanes(r.lane0, r.lane1, 1'b0);
		{stall_from_id_i, stall_from_ex_i, stall_from_mm_i} = r.stall_req;
		except_req_i = r.exc;
		if (r.push) begin
			fetch_valid_i = 1'b1;
			fetch_pc_i    = random_pc();
		end
		#10;
		check_vec("stall_if/id/ex/mm_o", stall_now(), r.vec_b[7:4]);
		check_vec("flush_if/id/ex/mm_o", flush_now(), r.vec_b[3:0]);
		check_bit("delayslot_not_exec_o", delayslot_not_exec_o, r.dslot[1]);
		if (r.push) begin
			check_bit("fetch_ready_o", fetch_ready_o, 1'b1);
		end
		next_cycle();

		set_lanes(LANE_OFF, LANE_OFF, 1'b0);
		{stall_from_id_i, stall_from_ex_i, stall_from_mm_i} = 3'b000;
		except_req_i  = EXC_NONE;
		fetch_valid_i = 1'b0;
		#10;
		check_vec("stall_if/id/ex/mm_o", stall_now(), r.vec_c[7:4]);
		check_vec("flush_if/id/ex/mm_o", flush_now(), r.vec_c[3:0]);
		check_bit("delayslot_not_exec_o", delayslot_not_exec_o, r.dslot[0]);
		next_cycle();

		if (r.redirect) begin
			wait_redirect(1'b1);
			check_addr("redirect_pc_o", redirect_pc_o, r.redirect_pc);
			for (int i = 0; i < r.hold_cycles; i++) begin
				next_cycle();
				#10;
				check_bit("redirect_valid_o", redirect_valid_o, 1'b1);
				check_addr("redirect_pc_o", redirect_pc_o, r.redirect_pc);
			end
			next_cycle();
			redirect_ready_i = 1'b1;
			wait_redirect(1'b0);
			next_cycle();
			redirect_ready_i = 1'b0;
		end else begin
			#10;
			check_bit("redirect_valid_o", redirect_valid_o, 1'b0);
			next_cycle();
		end
	endtask

	// Full queue refuses a push and keeps its order
	task automatic check_full_queue();
		addr_t pcs [3];
		addr_t popped [$];
		int    cycles;
		logic  accepted;
		for (int i = 0; i < 3; i++) begin
			pcs[i] = random_pc();
		end
		stall_from_id_i = 1'b1;
		for (int i = 0; i < 2; i++) begin
			fetch_valid_i = 1'b1;
			fetch_pc_i    = pcs[i];
			wait_fetch_ready();
			next_cycle();
		end
		fetch_pc_i = pcs[2];
		for (int i = 0; i < 3; i++) begin
			#10;
			check_bit("fetch_ready_o", fetch_ready_o, 1'b0);
			check_bit("issue_valid_o", issue_valid_o, 1'b1);
			check_addr("issue_pc_o", issue_pc_o, pcs[0]);
			next_cycle();
		end
		stall_from_id_i = 1'b0;
		cycles = 0;
		while (popped.size() < 3) begin
			if (cycles == TIMEOUT) begin
				$display("Timed out draining the fetch queue (%s)", phase);
				report_fail();
			end
			#10;
			if (issue_valid_o && !stall_id_o) begin
				popped.push_back(issue_pc_o);
			end
			accepted = fetch_valid_i & fetch_ready_o;
			next_cycle();
			if (accepted) begin
				fetch_valid_i = 1'b0;
			end
			cycles++;
		end
		for (int i = 0; i < 3; i++) begin
			check_addr("issue_pc_o", popped[i], pcs[i]);
		end
	endtask

	// **************************************************
	// Main sequence
	// **************************************************

	initial begin
		clk              = 1'b0;
		rst              = 1'b1;
		fetch_valid_i    = 1'b0;
		fetch_pc_i       = '0;
		exec_i           = '0;
		is_branch_i      = '0;
		predicted_taken_i = '0;
		actual_taken_i   = '0;
		actual_target_i  = '0;
		except_req_i     = EXC_NONE;
		stall_from_id_i  = 1'b0;
		stall_from_ex_i  = 1'b0;
		stall_from_mm_i  = 1'b0;
		redirect_ready_i = 1'b0;
		phase            = "reset";
		build_table();

		for (int i = 0; i < 5; i++) begin
			@(posedge clk);
			#1;
			check_vec("stall_if/id/ex/mm_o", stall_now(), 4'b1111);
			check_bit("redirect_valid_o", redirect_valid_o, 1'b0);
		end
		#1;
		rst = 1'b0;

		foreach (rows[i]) begin
			phase = $sformatf("row %0d", i);
			run_row(rows[i]);
		end

		phase = "fetch queue";
		check_full_queue();

		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/ctrl_top.sv
`default_nettype none
`timescale 1ns/1ns

`include "cpu_settings.svh"

module ctrl_top (
	input  logic                                   clk,
	input  logic                                   rst,

	input  logic                                   fetch_valid_i,
	input  cpu_pkg::addr_t                         fetch_pc_i,
	output logic                                   fetch_ready_o,
	output logic                                   issue_valid_o,
	output cpu_pkg::addr_t                         issue_pc_o,

	input  cpu_pkg::pipeline_exec_t [`LANE_NUM-1:0] exec_i,
	input  logic [`LANE_NUM-1:0]                   is_branch_i,
	input  logic [`LANE_NUM-1:0]                   predicted_taken_i,
	input  logic [`LANE_NUM-1:0]                   actual_taken_i,
	input  cpu_pkg::addr_t [`LANE_NUM-1:0]          actual_target_i,

	input  cpu_pkg::except_req_t                   except_req_i,

	input  logic                                   stall_from_id_i,
	input  logic                                   stall_from_ex_i,
	input  logic                                   stall_from_mm_i,
	output logic                                   stall_if_o,
	output logic                                   stall_id_o,
	output logic                                   stall_ex_o,
	output logic                                   stall_mm_o,
	output logic                                   flush_if_o,
	output logic                                   flush_id_o,
	output logic                                   flush_ex_o,
	output logic                                   flush_mm_o,
	output logic                                   delayslot_not_exec_o,

	output logic                                   redirect_valid_o,
	output cpu_pkg::addr_t                         redirect_pc_o,
	input  logic                                   redirect_ready_i
);
	import cpu_pkg::*;

	fetch_entry_t [`FETCH_NUM-1:0] fetch_entry;
	branch_resolved_t              resolved_branch;
	logic                          hold_resolved_branch;

	branch_if br_lane0 ();
	branch_if br_lane1 ();

	fetch_queue u_fetch_queue (
		.clk           (clk),
		.rst           (rst),
		.fetch_valid_i (fetch_valid_i),
		.fetch_pc_i    (fetch_pc_i),
		.fetch_ready_o (fetch_ready_o),
		.stall_id_i    (stall_id_o),
		.flush_if_i    (flush_if_o),
		.entry_o       (fetch_entry),
		.issue_valid_o (issue_valid_o),
		.issue_pc_o    (issue_pc_o)
	);

	// **************************************************
	// Execute lanes
	// **************************************************

	branch_resolver u_resolver0 (
		.clk               (clk),
		.rst               (rst),
		.exec_i            (exec_i[0]),
		.is_branch_i       (is_branch_i[0]),
		.predicted_taken_i (predicted_taken_i[0]),
		.actual_taken_i    (actual_taken_i[0]),
		.actual_target_i   (actual_target_i[0]),
		.hold_i            (hold_resolved_branch),
		.br                (br_lane0)
	);

	branch_resolver u_resolver1 (
		.clk               (clk),
		.rst               (rst),
		.exec_i            (exec_i[1]),
		.is_branch_i       (is_branch_i[1]),
		.predicted_taken_i (predicted_taken_i[1]),
		.actual_taken_i    (actual_taken_i[1]),
		.actual_target_i   (actual_target_i[1]),
		.hold_i            (hold_resolved_branch),
		.br                (br_lane1)
	);

	pipe_ctrl u_pipe_ctrl (
		.rst                    (rst),
		.stall_from_id_i        (stall_from_id_i),
		.stall_from_ex_i        (stall_from_ex_i),
		.stall_from_mm_i        (stall_from_mm_i),
		.stall_if_o             (stall_if_o),
		.stall_id_o             (stall_id_o),
		.stall_ex_o             (stall_ex_o),
		.stall_mm_o             (stall_mm_o),
		.flush_if_o             (flush_if_o),
		.flush_id_o             (flush_id_o),
		.flush_ex_o             (flush_ex_o),
		.flush_mm_o             (flush_mm_o),
		.except_req_i           (except_req_i),
		.fetch_entry_i          (fetch_entry),
		.pipeline_exec_i        (exec_i),
		.br0                    (br_lane0),
		.br1                    (br_lane1),
		.resolved_branch_o      (resolved_branch),
		.delayslot_not_exec_o   (delayslot_not_exec_o),
		.hold_resolved_branch_o (hold_resolved_branch)
	);

	// flush_id doubles as the mispredict flush, exception wins inside
	redirect_unit u_redirect (
		.clk                (clk),
		.rst                (rst),
		.except_req_i       (except_req_i),
		.flush_mispredict_i (flush_id_o),
		.resolved_branch_i  (resolved_branch),
		.redirect_valid_o   (redirect_valid_o),
		.redirect_pc_o      (redirect_pc_o),
		.redirect_ready_i   (redirect_ready_i)
	);

endmodule

`default_nettype wire

//--- logic/redirect_unit.sv
`default_nettype none
`timescale 1ns/1ns

module redirect_unit (
	input  logic                      clk,
	input  logic                      rst,

	input  cpu_pkg::except_req_t      except_req_i,
	input  logic                      flush_mispredict_i,
	input  cpu_pkg::branch_resolved_t resolved_branch_i,

	output logic                      redirect_valid_o,
	output cpu_pkg::addr_t            redirect_pc_o,
	input  logic                      redirect_ready_i
);
	import cpu_pkg::*;

	redirect_state_e state_q;
	redirect_state_e state_d;
	addr_t           target_q;
	addr_t           load_target;
	logic            load;

	// **************************************************
	// Target selection
	// **************************************************

	assign load = except_req_i.valid | flush_mispredict_i;

	// Exception beats a branch in the same cycle
	assign load_target = except_req_i.valid ? except_req_i.target
		: resolved_branch_i.target;

	always_ff @(posedge clk) begin
		if (load) begin
			target_q <= load_target;  // Newer flush replaces a pending offer
		end
	end

	// **************************************************
	// Offer FSM
	// **************************************************

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (load) begin
					state_d = OFFER;
				end
			end
			OFFER: begin
				if (load) begin
					state_d = OFFER;
				end else if (redirect_ready_i) begin
					state_d = IDLE;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	assign redirect_valid_o = (state_q == OFFER);
	assign redirect_pc_o    = target_q;

endmodule

`default_nettype wire

//--- logic/pipe_ctrl.sv
`default_nettype none
`timescale 1ns/1ns

`include "cpu_settings.svh"

module pipe_ctrl (
	input  logic                                  rst,
	input  logic                                  stall_from_id_i,
	input  logic                                  stall_from_ex_i,
	input  logic                                  stall_from_mm_i,
	output logic                                  stall_if_o,
	output logic                                  stall_id_o,
	output logic                                  stall_ex_o,
	output logic                                  stall_mm_o,
	output logic                                  flush_if_o,
	output logic                                  flush_id_o,
	output logic                                  flush_ex_o,
	output logic                                  flush_mm_o,

	input  cpu_pkg::except_req_t                  except_req_i,
	input  cpu_pkg::fetch_entry_t [`FETCH_NUM-1:0] fetch_entry_i,
	input  cpu_pkg::pipeline_exec_t [1:0]          pipeline_exec_i,
	branch_if.consumer                            br0,
	branch_if.consumer                            br1,
	output cpu_pkg::branch_resolved_t             resolved_branch_o,
	output logic                                  delayslot_not_exec_o,
	output logic                                  hold_resolved_branch_o
);
	import cpu_pkg::*;

	branch_resolved_t [1:0] lane_br;
	logic [3:0]             stall;  // IF, ID, EX, MM
	logic [3:0]             flush;
	logic [1:0]             mispredict;
	logic                   queue_has_entry;
	logic                   wait_delayslot;
	logic                   slot_blocked;
	logic                   flush_mispredict;

	assign {stall_if_o, stall_id_o, stall_ex_o, stall_mm_o} = stall;
	assign {flush_if_o, flush_id_o, flush_ex_o, flush_mm_o} = flush;

	always_comb begin
		lane_br[0] = {br0.valid, br0.mispredict, br0.taken, br0.pc, br0.target};
		lane_br[1] = {br1.valid, br1.mispredict, br1.taken, br1.pc, br1.target};
		for (int i = 0; i < 2; i++) begin
			mispredict[i] = lane_br[i].valid & lane_br[i].mispredict;
		end
	end

	// **************************************************
	// Delay slot tracking
	// **************************************************

	always_comb begin
		queue_has_entry = 1'b0;
		for (int i = 0; i < `FETCH_NUM; i++) begin
			queue_has_entry |= fetch_entry_i[i].valid;
		end
	end

	// Lane 1 branch always has its slot outside the lanes
	assign delayslot_not_exec_o = lane_br[1].valid
		| (lane_br[0].valid & ~pipeline_exec_i[1].valid);
	assign wait_delayslot = delayslot_not_exec_o & ~queue_has_entry;

	// Slot in lane 1 cannot move past a stalled EX
	assign slot_blocked = mispredict[0] & pipeline_exec_i[1].valid & stall[1];

	assign flush_mispredict = (|mispredict) & ~wait_delayslot
		& ~stall_from_ex_i & ~slot_blocked;

	// Youngest valid branch wins
	always_comb begin
		resolved_branch_o = '0;
		if (!wait_delayslot) begin
			for (int i = 0; i < 2; i++) begin
				if (lane_br[i].valid) begin
					resolved_branch_o = lane_br[i];
				end
			end
		end
	end

	// **************************************************
	// Stall and flush vectors
	// **************************************************

	always_comb begin
		if (rst || stall_from_mm_i) begin
			stall = 4'b1111;
		end else if (stall_from_ex_i || wait_delayslot) begin
			stall = 4'b1110;
		end else if (stall_from_id_i) begin
			stall = 4'b1100;
		end else begin
			stall = 4'b0000;
		end
	end

	always_comb begin
		flush = 4'b0000;
		if (except_req_i.valid) begin
			flush = {2'b11, {2{except_req_i.alpha_taken}}};
		end else if (flush_mispredict) begin
			flush = 4'b1100;
		end
	end

	assign hold_resolved_branch_o = (stall[1] | stall[0]) & ~flush[2];

endmodule

`default_nettype wire

//--- logic/branch_resolver.sv
`default_nettype none
`timescale 1ns/1ns

module branch_resolver (
	input  logic                    clk,
	input  logic                    rst,

	input  cpu_pkg::pipeline_exec_t exec_i,
	input  logic                    is_branch_i,
	input  logic                    predicted_taken_i,
	input  logic                    actual_taken_i,
	input  cpu_pkg::addr_t          actual_target_i,

	input  logic                    hold_i,

	branch_if.producer              br
);
	import cpu_pkg::*;

	logic  valid_d;
	logic  mispredict_d;
	addr_t target_d;

	logic  valid_q;
	logic  mispredict_q;
	logic  taken_q;
	addr_t pc_q;
	addr_t target_q;

	// **************************************************
	// Compare predicted and actual direction
	// **************************************************

	assign valid_d      = exec_i.valid & is_branch_i;
	assign mispredict_d = valid_d & (predicted_taken_i != actual_taken_i);

	// Not taken resumes past the delay slot
	assign target_d = actual_taken_i ? actual_target_i : exec_i.pc + addr_t'(8);

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q      <= 1'b0;
			mispredict_q <= 1'b0;
		end else if (!hold_i) begin
			valid_q      <= valid_d;
			mispredict_q <= mispredict_d;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold_i) begin
			taken_q  <= actual_taken_i;
			pc_q     <= exec_i.pc;
			target_q <= target_d;
		end
	end

	assign br.valid      = valid_q;
	assign br.mispredict = mispredict_q;
	assign br.taken      = taken_q;
	assign br.pc         = pc_q;
	assign br.target     = target_q;

endmodule

`default_nettype wire

//--- logic/fetch_queue.sv
`default_nettype none
`timescale 1ns/1ns

`include "cpu_settings.svh"

module fetch_queue (
	input  logic                                  clk,
	input  logic                                  rst,

	input  logic                                  fetch_valid_i,
	input  cpu_pkg::addr_t                        fetch_pc_i,
	output logic                                  fetch_ready_o,

	input  logic                                  stall_id_i,
	input  logic                                  flush_if_i,

	output cpu_pkg::fetch_entry_t [`FETCH_NUM-1:0] entry_o,
	output logic                                  issue_valid_o,
	output cpu_pkg::addr_t                        issue_pc_o
);
	import cpu_pkg::*;

	localparam int PTR_W = $clog2(`FETCH_NUM);

	logic [`FETCH_NUM-1:0] slot_valid;
	addr_t                 slot_pc [`FETCH_NUM];
	logic [PTR_W-1:0]      head;
	logic [PTR_W-1:0]      tail;
	logic                  push;
	logic                  pop;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(`FETCH_NUM - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// **************************************************
	// Handshakes
	// **************************************************

	// Tail slot free means the queue is not full
	assign fetch_ready_o = ~slot_valid[tail] & ~flush_if_i;
	assign push          = fetch_valid_i & fetch_ready_o;
	assign pop           = issue_valid_o & ~stall_id_i;

	assign issue_valid_o = slot_valid[head];
	assign issue_pc_o    = slot_pc[head];

	// **************************************************
	// Pointers and slot state
	// **************************************************

	always_ff @(posedge clk) begin
		if (rst || flush_if_i) begin
			head       <= '0;
			tail       <= '0;
			slot_valid <= '0;
		end else begin
			if (push) begin
				slot_valid[tail] <= 1'b1;
				tail             <= ptr_next(tail);
			end
			if (pop) begin
				slot_valid[head] <= 1'b0;  // Never the slot being pushed
				head             <= ptr_next(head);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			slot_pc[tail] <= fetch_pc_i;
		end
	end

	// Every slot is visible to control for the delay slot check
	always_comb begin
		for (int i = 0; i < `FETCH_NUM; i++) begin
			entry_o[i].valid = slot_valid[i];
			entry_o[i].pc    = slot_pc[i];
		end
	end

endmodule

`default_nettype wire

//--- logic/branch_if.sv
`default_nettype none
`timescale 1ns/1ns

// One lane's resolved branch
interface branch_if;

	logic           valid;
	logic           mispredict;
	logic           taken;
	cpu_pkg::addr_t pc;
	cpu_pkg::addr_t target;

	modport producer (
		output valid, mispredict, taken, pc, target
	);

	modport consumer (
		input valid, mispredict, taken, pc, target
	);

endinterface

`default_nettype wire

//--- logic/cpu_pkg.sv
`default_nettype none

`include "cpu_settings.svh"

package cpu_pkg;

	// **************************************************
	// Basic types
	// **************************************************

	typedef logic [`ADDR_WIDTH-1:0] addr_t;

	// One slot of the fetch queue
	typedef struct packed {
		logic  valid;
		addr_t pc;
	} fetch_entry_t;

	// Instruction sitting in an execute lane
	typedef struct packed {
		logic  valid;
		addr_t pc;
	} pipeline_exec_t;

	// **************************************************
	// Control flow records
	// **************************************************

	typedef struct packed {
		logic  valid;
		logic  mispredict;
		logic  taken;
		addr_t pc;
		addr_t target;     // Correct next fetch address
	} branch_resolved_t;

	typedef struct packed {
		logic  valid;
		logic  alpha_taken;  // Flush EX and MM as well
		addr_t target;
	} except_req_t;

	typedef enum logic {
		IDLE,
		OFFER
	} redirect_state_e;

endpackage

`default_nettype wire

//--- include/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// **************************************************
// Core sizing
// **************************************************

// Fetch queue depth, in instructions
`define FETCH_NUM 2

// Instruction address width
`define ADDR_WIDTH 32

// Execute lanes, lane 0 holds the older instruction
`define LANE_NUM 2

`endif
